//--- vlog.f
hw/rvIsaPkg.sv
hw/pipePkg.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/resolveStage.sv
hw/issuePipe.sv
dv/issuePipeTb.sv

//--- Bender.yml
package:
  name: issue_pipe

sources:
  - hw/rvIsaPkg.sv
  - hw/pipePkg.sv
  - hw/decodeStage.sv
  - hw/executeStage.sv
  - hw/resolveStage.sv
  - hw/issuePipe.sv
  - target: simulation
    files:
      - dv/issuePipeTb.sv

//--- dv/issuePipeTb.sv
`timescale 1ns/1ns
`default_nettype none
// ####################################################################
// Testbench for the RV32I issue pipeline
// Random instructions checked against a reference model
// ####################################################################

module issuePipeTb;

    localparam int NUM_TESTS = 2000;
    localparam int MAX_GAP   = 3;    // Idle cycles between strobes
    localparam int SEED      = 88;
    localparam int LATENCY   = 3;    // Issue-to-result cycles
    localparam int WATCHDOG  = 16 + NUM_TESTS * (MAX_GAP + 1) + LATENCY + 100;

    logic            clk;
    logic            reset_n;
    logic            issueValid;
    pipePkg::issueT  issue;
    logic            resultValid;
    pipePkg::resultT result;

    pipePkg::resultT expQ[$];    // Expected results in issue order
    string           nameQ[$];
    int              cycleQ[$];  // Issue cycle per entry
    int              cycleCount    = 0;
    int              mismatchCount = 0;
    int              otherCount    = 0;
    int              seedDummy;

    issuePipe u_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .issueValid  (issueValid),
        .issue       (issue),
        .resultValid (resultValid),
        .result      (result)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    function automatic logic isDefined(input logic [6:0] opc);
        case (opc)
            rvIsaPkg::OPC_LUI, rvIsaPkg::OPC_AUIPC, rvIsaPkg::OPC_JAL, rvIsaPkg::OPC_JALR,
            rvIsaPkg::OPC_BRANCH, rvIsaPkg::OPC_LOAD, rvIsaPkg::OPC_STORE,
            rvIsaPkg::OPC_OPIMM, rvIsaPkg::OPC_OP, rvIsaPkg::OPC_FENCE,
            rvIsaPkg::OPC_SYSTEM: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic string opName(input logic [6:0] opc);
        case (opc)
            rvIsaPkg::OPC_LUI:    return "lui";
            rvIsaPkg::OPC_AUIPC:  return "auipc";
            rvIsaPkg::OPC_JAL:    return "jal";
            rvIsaPkg::OPC_JALR:   return "jalr";
            rvIsaPkg::OPC_BRANCH: return "branch";
            rvIsaPkg::OPC_LOAD:   return "load";
            rvIsaPkg::OPC_STORE:  return "store";
            rvIsaPkg::OPC_OPIMM:  return "opimm";
            rvIsaPkg::OPC_OP:     return "op";
            rvIsaPkg::OPC_FENCE:  return "fence";
            rvIsaPkg::OPC_SYSTEM: return "system";
            default:              return "illegal";
        endcase
    endfunction

    // Integer ALU as the ISA defines it
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b, input logic subSel,
                                             input logic sraSel);
        logic [4:0] sh;
        sh = b[4:0];  // Shift amount from low bits
        case (f3)
            rvIsaPkg::F3_ADD:  return subSel ? a - b : a + b;
            rvIsaPkg::F3_SLL:  return a << sh;
            rvIsaPkg::F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            rvIsaPkg::F3_SLTU: return {31'b0, a < b};
            rvIsaPkg::F3_XOR:  return a ^ b;
            rvIsaPkg::F3_SR:   return sraSel ? $unsigned($signed(a) >>> sh) : a >> sh;
            rvIsaPkg::F3_OR:   return a | b;
            default:           return a & b;
        endcase
    endfunction

    function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            rvIsaPkg::F3_BEQ:  return a == b;
            rvIsaPkg::F3_BNE:  return a != b;
            rvIsaPkg::F3_BLT:  return $signed(a) < $signed(b);
            rvIsaPkg::F3_BGE:  return $signed(a) >= $signed(b);
            rvIsaPkg::F3_BLTU: return a < b;
            rvIsaPkg::F3_BGEU: return a >= b;
            default:           return 1'b0;  // Reserved compare never taken
        endcase
    endfunction

    // Expected result record for one instruction
    function automatic pipePkg::resultT modelResult(input pipePkg::issueT is);
        logic [31:0]     ins;
        logic [31:0]     immI;
        logic [31:0]     immS;
        logic [31:0]     immB;
        logic [31:0]     immU;
        logic [31:0]     immJ;
        logic [31:0]     aluRes;
        logic [31:0]     pc4;
        logic [31:0]     target;
        logic            write;
        logic            jump;
        logic            taken;
        pipePkg::resultT r;
        ins    = is.instr;
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU   = {ins[31:12], 12'b0};
        immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        r      = '0;
        write  = 1'b0;
        jump   = 1'b0;
        taken  = 1'b0;
        pc4    = is.pc + 32'd4;
        target = is.pc + immB;
        aluRes = is.rs1Data + is.rs2Data;  // Plain ADD on register operands
        case (ins[6:0])
            rvIsaPkg::OPC_LUI: begin
                aluRes = immU;
                write  = 1'b1;
            end
            rvIsaPkg::OPC_AUIPC: begin
                aluRes = is.pc + immU;
                write  = 1'b1;
            end
            rvIsaPkg::OPC_JAL: begin
                aluRes = is.pc + immJ;
                target = is.pc + immJ;
                jump   = 1'b1;
                write  = 1'b1;
            end
            rvIsaPkg::OPC_JALR: begin
                aluRes = is.pc + immI;
                target = (is.rs1Data + immI) & ~32'd1;  // Low bit dropped
                jump   = 1'b1;
                write  = 1'b1;
            end
            rvIsaPkg::OPC_BRANCH: begin
                aluRes = is.rs1Data - is.rs2Data;
                taken  = branchModel(ins[14:12], is.rs1Data, is.rs2Data);
            end
            rvIsaPkg::OPC_LOAD: begin
                aluRes     = is.rs1Data + immI;
                r.memRead  = 1'b1;
                r.memToReg = 1'b1;
                write      = 1'b1;
            end
            rvIsaPkg::OPC_STORE: begin
                aluRes     = is.rs1Data + immS;
                r.memWrite = 1'b1;
            end
            rvIsaPkg::OPC_OPIMM: begin
                aluRes = aluModel(ins[14:12], is.rs1Data, immI, 1'b0, ins[30]);
                write  = 1'b1;
            end
            rvIsaPkg::OPC_OP: begin
                aluRes = aluModel(ins[14:12], is.rs1Data, is.rs2Data, ins[30], ins[30]);
                write  = 1'b1;
            end
            rvIsaPkg::OPC_FENCE, rvIsaPkg::OPC_SYSTEM: ;  // No-ops
            default: r.illegal = 1'b1;
        endcase
        taken         = taken | jump;
        r.rdAddr      = ins[11:7];
        r.rdWrite     = write && (ins[11:7] != 5'd0);
        r.rdData      = jump ? pc4 : aluRes;  // Link value for jumps
        r.memAddr     = aluRes;
        r.storeData   = is.rs2Data;
        r.branchTaken = taken;
        r.nextPc      = taken ? target : pc4;
        return r;
    endfunction

    task automatic checkField(input string name, input string field, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            mismatchCount++;
            $display("mismatch %s %s expected %h actual %h", name, field, exp, act);
        end
    endtask

    task automatic compareResult(input string name, input pipePkg::resultT exp,
                                 input int issueCycle);
        checkField(name, "latency", issueCycle + LATENCY, cycleCount);
        checkField(name, "rdAddr", exp.rdAddr, result.rdAddr);
        checkField(name, "rdWrite", exp.rdWrite, result.rdWrite);
        checkField(name, "rdData", exp.rdData, result.rdData);
        checkField(name, "memRead", exp.memRead, result.memRead);
        checkField(name, "memWrite", exp.memWrite, result.memWrite);
        checkField(name, "memToReg", exp.memToReg, result.memToReg);
        checkField(name, "memAddr", exp.memAddr, result.memAddr);
        checkField(name, "storeData", exp.storeData, result.storeData);
        checkField(name, "branchTaken", exp.branchTaken, result.branchTaken);
        checkField(name, "nextPc", exp.nextPc, result.nextPc);
        checkField(name, "illegal", exp.illegal, result.illegal);
    endtask

    // Result checks at mid-cycle
    always @(negedge clk) begin
        if (reset_n && resultValid) begin
            if (expQ.size() == 0) begin
                otherCount++;
                $display("error: result at cycle %0d with no instruction in flight", cycleCount);
            end else begin
                compareResult(nameQ.pop_front(), expQ.pop_front(), cycleQ.pop_front());
            end
        end
        if (!resultValid && (result.rdWrite || result.memRead || result.memWrite)) begin
            otherCount++;
            $display("error: write or memory request on an idle result slot");
        end
    end

    task automatic sendInstr();
        pipePkg::issueT is;
        logic [6:0]     opc;
        int             pick;
        int             gap;
        pick = $urandom_range(99);
        if (pick < 12)      opc = rvIsaPkg::OPC_OP;
        else if (pick < 24) opc = rvIsaPkg::OPC_OPIMM;
        else if (pick < 34) opc = rvIsaPkg::OPC_LOAD;
        else if (pick < 44) opc = rvIsaPkg::OPC_STORE;
        else if (pick < 58) opc = rvIsaPkg::OPC_BRANCH;
        else if (pick < 64) opc = rvIsaPkg::OPC_JAL;
        else if (pick < 70) opc = rvIsaPkg::OPC_JALR;
        else if (pick < 76) opc = rvIsaPkg::OPC_LUI;
        else if (pick < 82) opc = rvIsaPkg::OPC_AUIPC;
        else if (pick < 87) opc = rvIsaPkg::OPC_FENCE;
        else if (pick < 92) opc = rvIsaPkg::OPC_SYSTEM;
        else begin
            opc = $urandom_range(127);
            while (isDefined(opc)) opc = $urandom_range(127);  // Undefined opcode only
        end
        is.instr      = $urandom();
        is.instr[6:0] = opc;
        is.pc         = $urandom() & ~32'd3;  // Word aligned
        is.rs1Data    = $urandom();
        is.rs2Data    = ($urandom_range(3) == 0) ? is.rs1Data : $urandom();  // Equal compares
        if (opc == rvIsaPkg::OPC_JAL || opc == rvIsaPkg::OPC_JALR) begin
            is.instr[21]     = 1'b0;  // Immediate bit 1 clear
            is.rs1Data[1:0]  = 2'b00;
        end
        if (opc == rvIsaPkg::OPC_BRANCH) is.instr[8] = 1'b0;  // Aligned branch offset
        issueValid = 1'b1;
        issue      = is;
        expQ.push_back(modelResult(is));
        nameQ.push_back(opName(opc));
        cycleQ.push_back(cycleCount);
        @(negedge clk);
        issueValid = 1'b0;
        gap = ($urandom_range(1) == 0) ? 0 : $urandom_range(MAX_GAP, 1);  // Half back-to-back
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        seedDummy  = $urandom(SEED);
        clk        = 1'b0;
        reset_n    = 1'b0;
        issueValid = 1'b0;
        issue      = '0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        repeat (5) @(negedge clk);  // Quiet window after reset
        repeat (NUM_TESTS) sendInstr();
        while (expQ.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // Catch stray results
        $display("errors: %0d mismatches, %0d other", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: run not done after %0d cycles, %0d results never came out",
                 WATCHDOG, expQ.size());
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/issuePipe.sv
`timescale 1ns/1ns
`default_nettype none
// ####################################################################
// RV32I issue pipeline top
// Decode, execute and resolve in three register stages
// ####################################################################

module issuePipe (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              issueValid,
    input  wire pipePkg::issueT    issue,
    output logic                   resultValid,
    output pipePkg::resultT        result
);

    logic               decValid;
    pipePkg::decodeRecT decRec;
    logic               exValid;
    pipePkg::execRecT   exRec;

    decodeStage u_decode (
        .clk        (clk),
        .reset_n    (reset_n),
        .issueValid (issueValid),
        .issue      (issue),
        .decValid   (decValid),
        .decRec     (decRec)
    );

    executeStage u_execute (
        .clk      (clk),
        .reset_n  (reset_n),
        .decValid (decValid),
        .decRec   (decRec),
        .exValid  (exValid),
        .exRec    (exRec)
    );

    resolveStage u_resolve (
        .clk         (clk),
        .reset_n     (reset_n),
        .exValid     (exValid),
        .exRec       (exRec),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

`default_nettype wire

//--- hw/resolveStage.sv
`timescale 1ns/1ns
`default_nettype none
// ####################################################################
// Resolve stage
// Branch compare, next pc, write-back value and memory request
// ####################################################################

module resolveStage (
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic               exValid,
    input  wire pipePkg::execRecT   exRec,
    output logic                    resultValid,
    output pipePkg::resultT         result
);

    logic                      condMet;
    logic                      taken;
    logic [rvIsaPkg::XLEN-1:0] pcPlus4;
    pipePkg::resultT           resNext;

    // Branch compare on the raw register values
    always_comb begin
        case (exRec.funct3)
            rvIsaPkg::F3_BEQ:  condMet = (exRec.rs1Data == exRec.rs2Data);
            rvIsaPkg::F3_BNE:  condMet = (exRec.rs1Data != exRec.rs2Data);
            rvIsaPkg::F3_BLT:  condMet = ($signed(exRec.rs1Data) < $signed(exRec.rs2Data));
            rvIsaPkg::F3_BGE:  condMet = ($signed(exRec.rs1Data) >= $signed(exRec.rs2Data));
            rvIsaPkg::F3_BLTU: condMet = (exRec.rs1Data < exRec.rs2Data);
            rvIsaPkg::F3_BGEU: condMet = (exRec.rs1Data >= exRec.rs2Data);
            default:           condMet = 1'b0;  // Reserved codes fall through
        endcase
    end

    assign taken   = exRec.ctrl.jump | (exRec.ctrl.branch & condMet);
    assign pcPlus4 = exRec.pc + rvIsaPkg::PC_STEP;

    always_comb begin
        resNext.rdAddr      = exRec.rdAddr;
        resNext.rdWrite     = exRec.ctrl.regWrite && (exRec.rdAddr != '0);  // x0 stays zero
        resNext.rdData      = exRec.ctrl.jump ? pcPlus4 : exRec.aluResult;  // Link value
        resNext.memRead     = exRec.ctrl.memRead;
        resNext.memWrite    = exRec.ctrl.memWrite;
        resNext.memToReg    = exRec.ctrl.memToReg;
        resNext.memAddr     = exRec.aluResult;
        resNext.storeData   = exRec.rs2Data;
        resNext.branchTaken = taken;
        resNext.nextPc      = taken ? exRec.jumpTarget : pcPlus4;
        resNext.illegal     = exRec.ctrl.illegal;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            resultValid <= 1'b0;
            result      <= '0;
        end else begin
            resultValid <= exValid;
            result      <= resNext;
        end
    end

    // Misaligned targets are not trapped, only reported
    targetAligned: assert property (@(posedge clk) disable iff (!reset_n)
        resultValid && result.branchTaken |-> result.nextPc[1:0] == 2'b00)
        else $warning("Misaligned control transfer to %h", result.nextPc);

endmodule

`default_nettype wire

//--- hw/executeStage.sv
`timescale 1ns/1ns
`default_nettype none
// ####################################################################
// Execute stage
// ALU control, operand select, ALU and jump target adder
// ####################################################################

module executeStage (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  decValid,
    input  wire pipePkg::decodeRecT    decRec,
    output logic                       exValid,
    output pipePkg::execRecT           exRec
);

    pipePkg::ctrlT                ctrl;
    pipePkg::aluFuncT             aluFunc;
    logic [rvIsaPkg::XLEN-1:0]    opA;
    logic [rvIsaPkg::XLEN-1:0]    opB;
    logic [rvIsaPkg::SHAMT_W-1:0] shamt;
    logic [rvIsaPkg::XLEN-1:0]    aluResult;
    logic [rvIsaPkg::XLEN-1:0]    jumpSum;
    logic [rvIsaPkg::XLEN-1:0]    jumpTarget;

    assign ctrl = decRec.ctrl;

    // ALU control
    always_comb begin
        case (ctrl.aluOp)
            pipePkg::ALUOP_BRANCH: aluFunc = pipePkg::ALU_SUB;
            pipePkg::ALUOP_FUNCT: begin
                case (decRec.funct3)
                    rvIsaPkg::F3_ADD:  // SUB only for register form
                        aluFunc = (!ctrl.aluSrc && decRec.funct7Alt) ? pipePkg::ALU_SUB
                                                                     : pipePkg::ALU_ADD;
                    rvIsaPkg::F3_SLL:  aluFunc = pipePkg::ALU_SLL;
                    rvIsaPkg::F3_SLT:  aluFunc = pipePkg::ALU_SLT;
                    rvIsaPkg::F3_SLTU: aluFunc = pipePkg::ALU_SLTU;
                    rvIsaPkg::F3_XOR:  aluFunc = pipePkg::ALU_XOR;
                    rvIsaPkg::F3_SR:   // Alt bit valid in both forms
                        aluFunc = decRec.funct7Alt ? pipePkg::ALU_SRA : pipePkg::ALU_SRL;
                    rvIsaPkg::F3_OR:   aluFunc = pipePkg::ALU_OR;
                    rvIsaPkg::F3_AND:  aluFunc = pipePkg::ALU_AND;
                    default:           aluFunc = pipePkg::ALU_ADD;
                endcase
            end
            default: aluFunc = pipePkg::ALU_ADD;  // Addresses, LUI, AUIPC
        endcase
    end

    // Operand select
    always_comb begin
        case (ctrl.srcA)
            pipePkg::SRCA_PC:   opA = decRec.pc;
            pipePkg::SRCA_ZERO: opA = '0;
            default:            opA = decRec.rs1Data;
        endcase
    end

    assign opB   = ctrl.aluSrc ? decRec.imm : decRec.rs2Data;
    assign shamt = opB[rvIsaPkg::SHAMT_W-1:0];

    always_comb begin
        case (aluFunc)
            pipePkg::ALU_SUB:  aluResult = opA - opB;
            pipePkg::ALU_SLL:  aluResult = opA << shamt;
            pipePkg::ALU_SLT:  aluResult = {{(rvIsaPkg::XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            pipePkg::ALU_SLTU: aluResult = {{(rvIsaPkg::XLEN-1){1'b0}}, opA < opB};
            pipePkg::ALU_XOR:  aluResult = opA ^ opB;
            pipePkg::ALU_SRL:  aluResult = opA >> shamt;
            pipePkg::ALU_SRA:  aluResult = $unsigned($signed(opA) >>> shamt);
            pipePkg::ALU_OR:   aluResult = opA | opB;
            pipePkg::ALU_AND:  aluResult = opA & opB;
            default:           aluResult = opA + opB;
        endcase
    end

    // JALR target is rs1 plus imm with bit 0 cleared
    assign jumpSum    = (ctrl.jumpReg ? decRec.rs1Data : decRec.pc) + decRec.imm;
    assign jumpTarget = {jumpSum[rvIsaPkg::XLEN-1:1], jumpSum[0] & ~ctrl.jumpReg};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exValid <= 1'b0;
            exRec   <= '0;
        end else begin
            exValid          <= decValid;
            exRec.ctrl       <= ctrl;  // Already cleared on idle slots
            exRec.pc         <= decRec.pc;
            exRec.aluResult  <= aluResult;
            exRec.jumpTarget <= jumpTarget;
            exRec.rs1Data    <= decRec.rs1Data;
            exRec.rs2Data    <= decRec.rs2Data;
            exRec.imm        <= decRec.imm;
            exRec.funct3     <= decRec.funct3;
            exRec.rdAddr     <= decRec.rdAddr;
        end
    end

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none
// ####################################################################
// Decode stage
// Control unit and immediate generator, one register stage
// ####################################################################

module decodeStage (
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic               issueValid,
    input  wire pipePkg::issueT     issue,
    output logic                    decValid,
    output pipePkg::decodeRecT      decRec
);

    logic [rvIsaPkg::ILEN-1:0] instr;
    rvIsaPkg::opcodeT          opcode;
    pipePkg::ctrlT             ctrl;
    logic [rvIsaPkg::XLEN-1:0] imm;
    pipePkg::decodeRecT        recNext;

    assign instr  = issue.instr;
    assign opcode = rvIsaPkg::opcodeT'(instr[rvIsaPkg::OPCODE_W-1:0]);

    // All-zero control means ALUOP_ADD with rs1 as operand A
    always_comb begin
        ctrl = '0;
        case (opcode)
            rvIsaPkg::OPC_LUI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.srcA     = pipePkg::SRCA_ZERO;  // 0 + imm
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::OPC_AUIPC: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.srcA     = pipePkg::SRCA_PC;    // pc + imm
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::OPC_JAL, rvIsaPkg::OPC_JALR: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.srcA     = pipePkg::SRCA_PC;
                ctrl.jump     = 1'b1;
                ctrl.jumpReg  = (opcode == rvIsaPkg::OPC_JALR);  // Target from rs1
                ctrl.regWrite = 1'b1;                           // Link register
            end
            rvIsaPkg::OPC_BRANCH: begin
                ctrl.aluOp  = pipePkg::ALUOP_BRANCH;
                ctrl.branch = 1'b1;
            end
            rvIsaPkg::OPC_LOAD: begin
                ctrl.aluSrc   = 1'b1;  // rs1 + imm address
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::OPC_STORE: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            rvIsaPkg::OPC_OPIMM: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = pipePkg::ALUOP_FUNCT;
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::OPC_OP: begin
                ctrl.aluOp    = pipePkg::ALUOP_FUNCT;  // Operand B from rs2
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::OPC_FENCE, rvIsaPkg::OPC_SYSTEM: ;  // No-ops with no writes
            default: ctrl.illegal = 1'b1;               // Writes stay cleared
        endcase
    end

    // Immediate by instruction format
    always_comb begin
        case (opcode)
            rvIsaPkg::OPC_STORE:  // S
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvIsaPkg::OPC_BRANCH:  // B
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rvIsaPkg::OPC_LUI, rvIsaPkg::OPC_AUIPC:  // U
                imm = {instr[31:12], 12'b0};
            rvIsaPkg::OPC_JAL:  // J
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:  // I
                imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        recNext.ctrl      = ctrl;
        recNext.pc        = issue.pc;
        recNext.rs1Data   = issue.rs1Data;
        recNext.rs2Data   = issue.rs2Data;
        recNext.imm       = imm;
        recNext.funct3    = instr[rvIsaPkg::FUNCT3_LSB +: 3];
        recNext.funct7Alt = instr[rvIsaPkg::FUNCT7_ALT];
        recNext.rdAddr    = instr[rvIsaPkg::RD_LSB +: rvIsaPkg::REG_ADDR_W];
        if (!issueValid) begin
            recNext.ctrl = '0;  // Idle slot carries no writes
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            decValid <= 1'b0;
            decRec   <= '0;
        end else begin
            decValid <= issueValid;
            decRec   <= recNext;
        end
    end

    memExclusive: assert property (@(posedge clk) disable iff (!reset_n)
        decValid |-> !(decRec.ctrl.memRead && decRec.ctrl.memWrite));

endmodule

`default_nettype wire

//--- hw/pipePkg.sv
`default_nettype none
// ####################################################################
// Pipeline types for the decode and execute path
// Control bundle, ALU enums and inter-stage records
// ####################################################################

package pipePkg;

    typedef enum logic [1:0] {
        ALUOP_ADD    = 2'b00,  // Address and upper-immediate work
        ALUOP_BRANCH = 2'b01,  // Compare by subtract
        ALUOP_FUNCT  = 2'b10   // From funct3 and funct7
    } aluOpT;

    typedef enum logic [1:0] {
        SRCA_REG  = 2'b00,
        SRCA_PC   = 2'b01,
        SRCA_ZERO = 2'b10
    } srcAT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } aluFuncT;

    typedef struct packed {
        logic  aluSrc;    // Operand B is the immediate
        aluOpT aluOp;
        srcAT  srcA;
        logic  branch;
        logic  jump;      // JAL and JALR
        logic  jumpReg;   // JALR only
        logic  memRead;
        logic  memWrite;
        logic  memToReg;  // Write-back from load data
        logic  regWrite;
        logic  illegal;
    } ctrlT;

    typedef struct packed {
        logic [rvIsaPkg::XLEN-1:0] pc;
        logic [rvIsaPkg::ILEN-1:0] instr;
        logic [rvIsaPkg::XLEN-1:0] rs1Data;
        logic [rvIsaPkg::XLEN-1:0] rs2Data;
    } issueT;

    typedef struct packed {
        ctrlT                            ctrl;
        logic [rvIsaPkg::XLEN-1:0]       pc;
        logic [rvIsaPkg::XLEN-1:0]       rs1Data;
        logic [rvIsaPkg::XLEN-1:0]       rs2Data;
        logic [rvIsaPkg::XLEN-1:0]       imm;
        logic [2:0]                      funct3;
        logic                            funct7Alt;
        logic [rvIsaPkg::REG_ADDR_W-1:0] rdAddr;
    } decodeRecT;

    typedef struct packed {
        ctrlT                            ctrl;
        logic [rvIsaPkg::XLEN-1:0]       pc;
        logic [rvIsaPkg::XLEN-1:0]       aluResult;
        logic [rvIsaPkg::XLEN-1:0]       jumpTarget;
        logic [rvIsaPkg::XLEN-1:0]       rs1Data;
        logic [rvIsaPkg::XLEN-1:0]       rs2Data;
        logic [rvIsaPkg::XLEN-1:0]       imm;
        logic [2:0]                      funct3;
        logic [rvIsaPkg::REG_ADDR_W-1:0] rdAddr;
    } execRecT;

    typedef struct packed {
        logic [rvIsaPkg::REG_ADDR_W-1:0] rdAddr;
        logic                            rdWrite;
        logic [rvIsaPkg::XLEN-1:0]       rdData;
        logic                            memRead;
        logic                            memWrite;
        logic                            memToReg;
        logic [rvIsaPkg::XLEN-1:0]       memAddr;
        logic [rvIsaPkg::XLEN-1:0]       storeData;
        logic                            branchTaken;
        logic [rvIsaPkg::XLEN-1:0]       nextPc;
        logic                            illegal;
    } resultT;

endpackage

`default_nettype wire

//--- hw/rvIsaPkg.sv
`default_nettype none
// ####################################################################
// RV32I ISA definitions
// Opcodes, funct3 codes and instruction field positions
// ####################################################################

package rvIsaPkg;

    localparam int XLEN       = 32;  // Data and address width
    localparam int ILEN       = 32;  // Instruction word width
    localparam int OPCODE_W   = 7;
    localparam int REG_ADDR_W = 5;   // x0..x31
    localparam int SHAMT_W    = 5;   // Shift amount bits
    localparam int RD_LSB     = 7;   // rd field base
    localparam int FUNCT3_LSB = 12;  // funct3 field base
    localparam int FUNCT7_ALT = 30;  // Selects SUB and SRA

    localparam logic [XLEN-1:0] PC_STEP = 32'd4;  // Sequential fetch step

    // Base opcode map
    typedef enum logic [OPCODE_W-1:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011
    } opcodeT;

    // Branch compares
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU groups for OP and OPIMM
    localparam logic [2:0] F3_ADD  = 3'b000;  // ADD or SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

`default_nettype wire
